//--- hdl/icache_pkg.sv
// icache package: cache geometry, controller states and the memory return word formats
package icache_pkg;

  ////////////////////
  // geometry
  ////////////////////

  // physical address split as tag | index | offset
  localparam int PADDR_WIDTH  = 16;
  localparam int NUM_WAYS     = 4;
  localparam int WAY_WIDTH    = 2;
  // 16-byte lines
  localparam int OFFSET_WIDTH = 4;
  localparam int INDEX_WIDTH  = 4;
  localparam int NUM_SETS     = 16;
  localparam int TAG_WIDTH    = PADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;
  localparam int LINE_WIDTH   = 128;
  localparam int FETCH_WIDTH  = 32;
  // per-way age, saturates at NUM_WAYS-1
  localparam int AGE_WIDTH    = 2;

  ////////////////////
  // controller states
  ////////////////////

  localparam int          STATE_WIDTH = 2;
  localparam logic [1:0]  ST_FLUSH    = 2'd0;
  localparam logic [1:0]  ST_IDLE     = 2'd1;
  localparam logic [1:0]  ST_READ     = 2'd2;
  localparam logic [1:0]  ST_MISS     = 2'd3;

  ////////////////////
  // memory return
  ////////////////////

  // return type, one bit
  localparam logic RTRN_FILL = 1'b0;
  localparam logic RTRN_INV  = 1'b1;

  // unused upper bits of an invalidation record
  localparam int INV_PAD_WIDTH = LINE_WIDTH - INDEX_WIDTH - WAY_WIDTH - 2;

  // invalidation record, lives in the low bits of the return word
  typedef struct packed {
    logic [INV_PAD_WIDTH-1:0] pad;
    logic [INDEX_WIDTH-1:0]   idx;
    logic [WAY_WIDTH-1:0]     way;
    logic                     one_way;
    logic                     all_ways;
  } inv_req_t;

  // one return word, read as a refill line or as an invalidation
  typedef union packed {
    logic [LINE_WIDTH-1:0] fill;
    inv_req_t              inv;
  } rtrn_word_u;

endpackage

//--- hdl/icache_ctrl.sv
// icache controller: sequences flush, lookup, miss and refill for the fetch port
`timescale 1ns/1ps

module icache_ctrl (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic                                flush_i,
  input  logic                                req_i,
  input  logic [icache_pkg::PADDR_WIDTH-1:0]  paddr_i,
  input  logic                                hit_i,
  input  logic                                mem_ack_i,
  input  logic                                rtrn_vld_i,
  input  logic                                rtrn_type_i,
  output logic                                ready_o,
  output logic                                valid_o,
  output logic                                miss_o,
  output logic                                mem_req_o,
  output logic [icache_pkg::PADDR_WIDTH-1:0]  mem_addr_o,
  output logic                                lookup_o,
  output logic                                refill_o,
  output logic                                flush_o,
  output logic [icache_pkg::INDEX_WIDTH-1:0]  flush_set_o,
  output logic                                inv_o,
  output logic [icache_pkg::TAG_WIDTH-1:0]    tag_q_o,
  output logic [icache_pkg::INDEX_WIDTH-1:0]  index_o,
  output logic [icache_pkg::OFFSET_WIDTH-1:0] offset_q_o,
  output logic                                from_fill_o
);

  logic [icache_pkg::STATE_WIDTH-1:0] state_d, state_q;
  // pending flush request
  logic                               flush_d, flush_q;
  logic [icache_pkg::INDEX_WIDTH-1:0] flush_cnt_q;
  logic                               flush_done;
  logic                               fill_rtrn;
  logic [icache_pkg::INDEX_WIDTH-1:0] index_q;

  ////////////////////
  // return decode
  ////////////////////

  // invalidations are handled in any state
  assign inv_o     = rtrn_vld_i && (rtrn_type_i == icache_pkg::RTRN_INV);
  assign fill_rtrn = rtrn_vld_i && (rtrn_type_i == icache_pkg::RTRN_FILL);

  // the array reads the new set on acceptance, else the held one
  assign index_o     = lookup_o ? paddr_i[icache_pkg::OFFSET_WIDTH +: icache_pkg::INDEX_WIDTH]
                                : index_q;
  assign mem_addr_o  = {tag_q_o, index_q, {icache_pkg::OFFSET_WIDTH{1'b0}}};
  // output word comes from the return line unless comparing
  assign from_fill_o = (state_q != icache_pkg::ST_READ);
  assign flush_set_o = flush_cnt_q;
  assign flush_done  = (flush_cnt_q == icache_pkg::INDEX_WIDTH'(icache_pkg::NUM_SETS - 1));

  ////////////////////
  // state machine
  ////////////////////

  always_comb begin
    state_d   = state_q;
    flush_d   = flush_q | flush_i;
    ready_o   = 1'b0;
    valid_o   = 1'b0;
    miss_o    = 1'b0;
    mem_req_o = 1'b0;
    lookup_o  = 1'b0;
    refill_o  = 1'b0;
    flush_o   = 1'b0;

    case (state_q)
      // clear one set per cycle
      icache_pkg::ST_FLUSH: begin
        flush_o = 1'b1;
        if (flush_done) begin
          flush_d = 1'b0;
          state_d = icache_pkg::ST_IDLE;
        end
      end
      // wait for a fetch, pending flush first
      icache_pkg::ST_IDLE: begin
        if (flush_d) begin
          state_d = icache_pkg::ST_FLUSH;
        end else if (!inv_o) begin
          ready_o = 1'b1;
          if (req_i) begin
            lookup_o = 1'b1;
            state_d  = icache_pkg::ST_READ;
          end
        end
      end
      // tag compare on the registered array read
      icache_pkg::ST_READ: begin
        if (hit_i) begin
          valid_o = 1'b1;
          state_d = icache_pkg::ST_IDLE;
          // a pending flush takes the place of the next fetch
          if (flush_d) begin
            state_d = icache_pkg::ST_FLUSH;
          end else if (!inv_o) begin
            ready_o = 1'b1;
            if (req_i) begin
              lookup_o = 1'b1;
              state_d  = icache_pkg::ST_READ;
            end
          end
        end else begin
          // hold the refill request until it is taken
          mem_req_o = 1'b1;
          if (mem_ack_i) begin
            miss_o  = 1'b1;
            state_d = icache_pkg::ST_MISS;
          end
        end
      end
      // wait for the line, skip the write if a flush is pending
      icache_pkg::ST_MISS: begin
        if (fill_rtrn) begin
          valid_o  = 1'b1;
          refill_o = !flush_d;
          state_d  = icache_pkg::ST_IDLE;
        end
      end
      default: begin
        state_d = icache_pkg::ST_FLUSH;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= icache_pkg::ST_FLUSH;
      flush_q     <= 1'b0;
      flush_cnt_q <= '0;
    end else begin
      state_q <= state_d;
      flush_q <= flush_d;
      if (flush_o) begin
        flush_cnt_q <= flush_done ? '0 : flush_cnt_q + 1'b1;
      end
    end
  end

  // accepted fetch address
  always_ff @(posedge clk_i) begin
    if (lookup_o) begin
      tag_q_o    <= paddr_i[icache_pkg::PADDR_WIDTH-1 -: icache_pkg::TAG_WIDTH];
      index_q    <= paddr_i[icache_pkg::OFFSET_WIDTH +: icache_pkg::INDEX_WIDTH];
      offset_q_o <= paddr_i[icache_pkg::OFFSET_WIDTH-1:0];
    end
  end

endmodule

//--- hdl/icache_arrays.sv
// icache arrays: per-way tag, valid and line storage with a registered read port
`timescale 1ns/1ps

module icache_arrays (
  input  logic                                                      clk_i,
  input  logic                                                      rst_ni,
  input  logic                                                      lookup_i,
  input  logic                                                      refill_i,
  input  logic                                                      flush_i,
  input  logic [icache_pkg::INDEX_WIDTH-1:0]                        flush_set_i,
  input  logic                                                      inv_i,
  input  icache_pkg::inv_req_t                                      inv_req_i,
  input  logic [icache_pkg::INDEX_WIDTH-1:0]                        index_i,
  input  logic [icache_pkg::TAG_WIDTH-1:0]                          tag_i,
  input  logic [icache_pkg::WAY_WIDTH-1:0]                          repl_way_i,
  input  logic [icache_pkg::LINE_WIDTH-1:0]                         line_i,
  output logic [icache_pkg::NUM_WAYS-1:0][icache_pkg::TAG_WIDTH-1:0]  tag_rd_o,
  output logic [icache_pkg::NUM_WAYS-1:0]                           valid_rd_o,
  output logic [icache_pkg::NUM_WAYS-1:0][icache_pkg::LINE_WIDTH-1:0] line_rd_o
);

  logic [icache_pkg::TAG_WIDTH-1:0]  tag_mem  [icache_pkg::NUM_WAYS][icache_pkg::NUM_SETS];
  logic [icache_pkg::LINE_WIDTH-1:0] line_mem [icache_pkg::NUM_WAYS][icache_pkg::NUM_SETS];
  logic [icache_pkg::NUM_WAYS-1:0]   valid_q  [icache_pkg::NUM_SETS];

  logic [icache_pkg::INDEX_WIDTH-1:0] addr;
  logic [icache_pkg::NUM_WAYS-1:0]    way_en;
  // refill write, only when no flush or invalidation owns the port
  logic                               fill_we;

  // flush wins over invalidation, invalidation over lookup and refill
  always_comb begin
    fill_we = 1'b0;
    way_en  = '0;
    if (flush_i) begin
      addr   = flush_set_i;
      way_en = '1;
    end else if (inv_i) begin
      addr = inv_req_i.idx;
      if (inv_req_i.all_ways) begin
        way_en = '1;
      end else if (inv_req_i.one_way) begin
        way_en[inv_req_i.way] = 1'b1;
      end
    end else begin
      addr    = index_i;
      fill_we = refill_i;
      if (refill_i) begin
        way_en[repl_way_i] = 1'b1;
      end
    end
  end

  // valid bits, set by refill and cleared by flush or invalidation
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int s = 0; s < icache_pkg::NUM_SETS; s++) begin
        valid_q[s] <= '0;
      end
      valid_rd_o <= '0;
    end else begin
      for (int w = 0; w < icache_pkg::NUM_WAYS; w++) begin
        if (way_en[w]) begin
          valid_q[addr][w] <= fill_we;
        end
      end
      if (lookup_i) begin
        valid_rd_o <= valid_q[addr];
      end
    end
  end

  // tag and line storage, read data held until the next lookup
  always_ff @(posedge clk_i) begin
    for (int w = 0; w < icache_pkg::NUM_WAYS; w++) begin
      if (fill_we && way_en[w]) begin
        tag_mem[w][addr]  <= tag_i;
        line_mem[w][addr] <= line_i;
      end
      if (lookup_i) begin
        tag_rd_o[w]  <= tag_mem[w][addr];
        line_rd_o[w] <= line_mem[w][addr];
      end
    end
  end

endmodule

//--- hdl/icache_hit_select.sv
// icache hit select: tag compare, hit way encode and fetch word mux
`timescale 1ns/1ps

module icache_hit_select (
  input  logic [icache_pkg::TAG_WIDTH-1:0]                          tag_i,
  input  logic [icache_pkg::NUM_WAYS-1:0][icache_pkg::TAG_WIDTH-1:0]  tag_rd_i,
  input  logic [icache_pkg::NUM_WAYS-1:0]                           valid_rd_i,
  input  logic [icache_pkg::NUM_WAYS-1:0][icache_pkg::LINE_WIDTH-1:0] line_rd_i,
  input  logic [icache_pkg::OFFSET_WIDTH-1:0]                       offset_i,
  input  logic [icache_pkg::LINE_WIDTH-1:0]                         fill_line_i,
  input  logic                                                      from_fill_i,
  output logic                                                      hit_o,
  output logic [icache_pkg::WAY_WIDTH-1:0]                          hit_way_o,
  output logic [icache_pkg::FETCH_WIDTH-1:0]                        data_o
);

  logic [icache_pkg::NUM_WAYS-1:0]       way_hit;
  // word within the line, low two bits are the byte in the word
  logic [icache_pkg::OFFSET_WIDTH-3:0]   word_sel;
  logic [icache_pkg::LINE_WIDTH-1:0]     hit_line;

  assign word_sel = offset_i[icache_pkg::OFFSET_WIDTH-1:2];

  // compare every valid way, lowest hitting way wins
  always_comb begin
    hit_way_o = '0;
    for (int w = icache_pkg::NUM_WAYS - 1; w >= 0; w--) begin
      way_hit[w] = valid_rd_i[w] && (tag_rd_i[w] == tag_i);
      if (way_hit[w]) begin
        hit_way_o = icache_pkg::WAY_WIDTH'(w);
      end
    end
  end

  // no hit outside the compare cycle
  assign hit_o = (|way_hit) && !from_fill_i;

  ////////////////////
  // word select
  ////////////////////

  // refill returns bypass the arrays
  assign hit_line = from_fill_i ? fill_line_i : line_rd_i[hit_way_o];
  assign data_o   = hit_line[word_sel*icache_pkg::FETCH_WIDTH +: icache_pkg::FETCH_WIDTH];

endmodule

//--- hdl/icache_lru.sv
// icache replacement: per-set age counters and choice of the way to refill
`timescale 1ns/1ps

module icache_lru (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic [icache_pkg::INDEX_WIDTH-1:0]  index_i,
  input  logic [icache_pkg::NUM_WAYS-1:0]     valid_rd_i,
  input  logic                                hit_i,
  input  logic [icache_pkg::WAY_WIDTH-1:0]    hit_way_i,
  input  logic                                refill_i,
  input  logic                                flush_i,
  input  logic [icache_pkg::INDEX_WIDTH-1:0]  flush_set_i,
  output logic [icache_pkg::WAY_WIDTH-1:0]    repl_way_o
);

  logic [icache_pkg::AGE_WIDTH-1:0] ages_q [icache_pkg::NUM_SETS][icache_pkg::NUM_WAYS];
  // set of the request being compared, follows the array read
  logic [icache_pkg::INDEX_WIDTH-1:0] idx_q;
  logic [icache_pkg::WAY_WIDTH-1:0]   inv_way;
  logic [icache_pkg::WAY_WIDTH-1:0]   lru_way;
  logic [icache_pkg::WAY_WIDTH-1:0]   used_way;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      idx_q <= '0;
    end else begin
      idx_q <= index_i;
    end
  end

  ////////////////////
  // replacement way
  ////////////////////

  // valid bits and ages stay put from compare to refill,
  // so the choice is held through the whole miss
  always_comb begin
    inv_way = '0;
    for (int w = icache_pkg::NUM_WAYS - 1; w >= 0; w--) begin
      if (!valid_rd_i[w]) begin
        inv_way = icache_pkg::WAY_WIDTH'(w);
      end
    end
    // highest way with a saturated age
    lru_way = icache_pkg::WAY_WIDTH'(icache_pkg::NUM_WAYS - 1);
    for (int w = 0; w < icache_pkg::NUM_WAYS; w++) begin
      if (ages_q[idx_q][w] == '1) begin
        lru_way = icache_pkg::WAY_WIDTH'(w);
      end
    end
  end

  assign repl_way_o = (&valid_rd_i) ? lru_way : inv_way;
  assign used_way   = refill_i ? repl_way_o : hit_way_i;

  ////////////////////
  // age update
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int s = 0; s < icache_pkg::NUM_SETS; s++) begin
        for (int w = 0; w < icache_pkg::NUM_WAYS; w++) begin
          ages_q[s][w] <= '0;
        end
      end
    end else if (flush_i) begin
      // flushed set restarts with distinct ages
      for (int w = 0; w < icache_pkg::NUM_WAYS; w++) begin
        ages_q[flush_set_i][w] <= icache_pkg::AGE_WIDTH'(w);
      end
    end else if (hit_i || refill_i) begin
      // used way gets youngest, the rest age and saturate
      for (int w = 0; w < icache_pkg::NUM_WAYS; w++) begin
        if (icache_pkg::WAY_WIDTH'(w) == used_way) begin
          ages_q[idx_q][w] <= '0;
        end else if (ages_q[idx_q][w] != '1) begin
          ages_q[idx_q][w] <= ages_q[idx_q][w] + 1'b1;
        end
      end
    end
  end

endmodule

//--- hdl/icache_top.sv
// icache top: set-associative instruction cache with line refill and invalidation
`timescale 1ns/1ps

module icache_top (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic                                flush_i,
  // fetch port
  input  logic                                req_i,
  input  logic [icache_pkg::PADDR_WIDTH-1:0]  paddr_i,
  output logic                                ready_o,
  output logic                                valid_o,
  output logic [icache_pkg::FETCH_WIDTH-1:0]  data_o,
  // miss pulse for the performance counter
  output logic                                miss_o,
  // refill request
  output logic                                mem_req_o,
  output logic [icache_pkg::PADDR_WIDTH-1:0]  mem_addr_o,
  output logic [icache_pkg::WAY_WIDTH-1:0]    mem_way_o,
  input  logic                                mem_ack_i,
  // memory return, fill line or invalidation
  input  logic                                rtrn_vld_i,
  input  logic                                rtrn_type_i,
  input  icache_pkg::rtrn_word_u              rtrn_i
);

  logic                                                      hit;
  logic [icache_pkg::WAY_WIDTH-1:0]                          hit_way;
  logic                                                      lookup;
  logic                                                      refill;
  logic                                                      flush;
  logic [icache_pkg::INDEX_WIDTH-1:0]                        flush_set;
  logic                                                      inv;
  logic [icache_pkg::TAG_WIDTH-1:0]                          tag_q;
  logic [icache_pkg::INDEX_WIDTH-1:0]                        index;
  logic [icache_pkg::OFFSET_WIDTH-1:0]                       offset_q;
  logic                                                      from_fill;
  logic [icache_pkg::NUM_WAYS-1:0][icache_pkg::TAG_WIDTH-1:0]  tag_rd;
  logic [icache_pkg::NUM_WAYS-1:0]                           valid_rd;
  logic [icache_pkg::NUM_WAYS-1:0][icache_pkg::LINE_WIDTH-1:0] line_rd;

  icache_ctrl i_ctrl (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .flush_i     ( flush_i     ),
    .req_i       ( req_i       ),
    .paddr_i     ( paddr_i     ),
    .hit_i       ( hit         ),
    .mem_ack_i   ( mem_ack_i   ),
    .rtrn_vld_i  ( rtrn_vld_i  ),
    .rtrn_type_i ( rtrn_type_i ),
    .ready_o     ( ready_o     ),
    .valid_o     ( valid_o     ),
    .miss_o      ( miss_o      ),
    .mem_req_o   ( mem_req_o   ),
    .mem_addr_o  ( mem_addr_o  ),
    .lookup_o    ( lookup      ),
    .refill_o    ( refill      ),
    .flush_o     ( flush       ),
    .flush_set_o ( flush_set   ),
    .inv_o       ( inv         ),
    .tag_q_o     ( tag_q       ),
    .index_o     ( index       ),
    .offset_q_o  ( offset_q    ),
    .from_fill_o ( from_fill   )
  );

  // the refill way is the one announced with the request
  icache_arrays i_arrays (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .lookup_i    ( lookup      ),
    .refill_i    ( refill      ),
    .flush_i     ( flush       ),
    .flush_set_i ( flush_set   ),
    .inv_i       ( inv         ),
    .inv_req_i   ( rtrn_i.inv  ),
    .index_i     ( index       ),
    .tag_i       ( tag_q       ),
    .repl_way_i  ( mem_way_o   ),
    .line_i      ( rtrn_i.fill ),
    .tag_rd_o    ( tag_rd      ),
    .valid_rd_o  ( valid_rd    ),
    .line_rd_o   ( line_rd     )
  );

  icache_hit_select i_hit_select (
    .tag_i       ( tag_q       ),
    .tag_rd_i    ( tag_rd      ),
    .valid_rd_i  ( valid_rd    ),
    .line_rd_i   ( line_rd     ),
    .offset_i    ( offset_q    ),
    .fill_line_i ( rtrn_i.fill ),
    .from_fill_i ( from_fill   ),
    .hit_o       ( hit         ),
    .hit_way_o   ( hit_way     ),
    .data_o      ( data_o      )
  );

  icache_lru i_lru (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .index_i     ( index       ),
    .valid_rd_i  ( valid_rd    ),
    .hit_i       ( hit         ),
    .hit_way_i   ( hit_way     ),
    .refill_i    ( refill      ),
    .flush_i     ( flush       ),
    .flush_set_i ( flush_set   ),
    .repl_way_o  ( mem_way_o   )
  );

endmodule

//--- test/tb_icache.sv
// icache testbench that checks table-driven fetches, invalidations and flushes against a model
`timescale 1ns/1ps

module tb_icache;

  // table operations
  localparam logic [1:0] OP_FETCH   = 2'd0;
  localparam logic [1:0] OP_INV_WAY = 2'd1;
  localparam logic [1:0] OP_INV_SET = 2'd2;
  localparam logic [1:0] OP_FLUSH   = 2'd3;
  localparam int         AGE_MAX    = (1 << icache_pkg::AGE_WIDTH) - 1;

  logic                               clk_i;
  logic                               rst_ni;
  logic                               flush_i;
  logic                               req_i;
  logic [icache_pkg::PADDR_WIDTH-1:0] paddr_i;
  logic                               ready_o;
  logic                               valid_o;
  logic [icache_pkg::FETCH_WIDTH-1:0] data_o;
  logic                               miss_o;
  logic                               mem_req_o;
  logic [icache_pkg::PADDR_WIDTH-1:0] mem_addr_o;
  logic [icache_pkg::WAY_WIDTH-1:0]   mem_way_o;
  logic                               mem_ack_i;
  logic                               rtrn_vld_i;
  logic                               rtrn_type_i;
  icache_pkg::rtrn_word_u             rtrn_i;

  // reference model of tags, valid bits and ages
  logic [icache_pkg::TAG_WIDTH-1:0] m_tag   [icache_pkg::NUM_SETS][icache_pkg::NUM_WAYS];
  logic                             m_valid [icache_pkg::NUM_SETS][icache_pkg::NUM_WAYS];
  int                               m_age   [icache_pkg::NUM_SETS][icache_pkg::NUM_WAYS];

  // entry is {op, hit, count, way, addr}
  logic [23:0] stim_q[$];
  logic [31:0] lfsr_q;
  int          flush_ops;
  int          cycle_cnt;
  int          cycle_limit;
  int          miss_cnt;
  int          valid_cnt;
  int          exp_miss;
  int          exp_valid;

  icache_top dut0 (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .flush_i     ( flush_i     ),
    .req_i       ( req_i       ),
    .paddr_i     ( paddr_i     ),
    .ready_o     ( ready_o     ),
    .valid_o     ( valid_o     ),
    .data_o      ( data_o      ),
    .miss_o      ( miss_o      ),
    .mem_req_o   ( mem_req_o   ),
    .mem_addr_o  ( mem_addr_o  ),
    .mem_way_o   ( mem_way_o   ),
    .mem_ack_i   ( mem_ack_i   ),
    .rtrn_vld_i  ( rtrn_vld_i  ),
    .rtrn_type_i ( rtrn_type_i ),
    .rtrn_i      ( rtrn_i      )
  );

  always #20 clk_i = ~clk_i;

  // count miss_o and valid_o pulses mid-cycle
  always @(negedge clk_i) begin
    if (rst_ni && miss_o) begin
      miss_cnt = miss_cnt + 1;
    end
    if (rst_ni && valid_o) begin
      valid_cnt = valid_cnt + 1;
    end
  end

  // watchdog
  always @(posedge clk_i) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt > cycle_limit) begin
      $display("timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("RESULT: FAIL");
      $fatal(1, "simulation hung");
    end
  end

  ////////////////////
  // helpers
  ////////////////////

  task automatic check_val(input logic [31:0] got, input logic [31:0] exp, input string msg);
    if (got !== exp) begin
      $display("mismatch at %0t: %s, got %0h expected %0h", $time, msg, got, exp);
      $display("RESULT: FAIL");
      $fatal(1, "first error");
    end
  endtask

  // 32-bit Galois LFSR shifting right
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h8020_0003;
    end else begin
      return s >> 1;
    end
  endfunction

  task automatic draw_bits(input int n, output int v);
    v = 0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v      = (v << 1) | int'(lfsr_q[0]);
    end
  endtask

  // each memory word holds its own byte address
  function automatic logic [31:0] word_of(input logic [15:0] a);
    return 32'({a[15:2], 2'b00});
  endfunction

  function automatic logic [127:0] line_of(input logic [15:0] a);
    logic [127:0] l;
    for (int k = 0; k < 4; k++) begin
      l[32*k +: 32] = word_of({a[15:4], 4'b0000} + 16'(4 * k));
    end
    return l;
  endfunction

  ////////////////////
  // reference model
  ////////////////////

  function automatic int find_way(input int s, input logic [7:0] t);
    for (int w = 0; w < icache_pkg::NUM_WAYS; w++) begin
      if (m_valid[s][w] && m_tag[s][w] == t) begin
        return w;
      end
    end
    return -1;
  endfunction

  // lowest invalid way or else the highest way that has aged out
  function automatic int pick_victim(input int s);
    for (int w = 0; w < icache_pkg::NUM_WAYS; w++) begin
      if (!m_valid[s][w]) begin
        return w;
      end
    end
    for (int w = icache_pkg::NUM_WAYS - 1; w >= 0; w--) begin
      if (m_age[s][w] == AGE_MAX) begin
        return w;
      end
    end
    return icache_pkg::NUM_WAYS - 1;
  endfunction

  task automatic update_ages(input int s, input int used);
    for (int w = 0; w < icache_pkg::NUM_WAYS; w++) begin
      if (w == used) begin
        m_age[s][w] = 0;
      end else if (m_age[s][w] < AGE_MAX) begin
        m_age[s][w] = m_age[s][w] + 1;
      end
    end
  endtask

  task automatic clear_model();
    for (int s = 0; s < icache_pkg::NUM_SETS; s++) begin
      for (int w = 0; w < icache_pkg::NUM_WAYS; w++) begin
        m_valid[s][w] = 1'b0;
        m_age[s][w]   = w;
      end
    end
  endtask

  ////////////////////
  // stimulus
  ////////////////////

  task automatic add_entry(input logic [1:0] op, input logic [15:0] addr, input int way,
                           input int count, input logic hit);
    stim_q.push_back({op, hit, 3'(count), 2'(way), addr});
    if (op == OP_FLUSH) begin
      flush_ops = flush_ops + 1;
    end
  endtask

  task automatic build_table();
    // cold misses in four sets
    add_entry(OP_FETCH, 16'h0100, 0, 1, 1'b0);
    add_entry(OP_FETCH, 16'h0214, 0, 1, 1'b0);
    add_entry(OP_FETCH, 16'h0328, 0, 1, 1'b0);
    add_entry(OP_FETCH, 16'h043c, 0, 1, 1'b0);
    // hits with some back to back
    add_entry(OP_FETCH, 16'h0104, 0, 1, 1'b1);
    add_entry(OP_FETCH, 16'h0100, 0, 4, 1'b1);
    add_entry(OP_FETCH, 16'h0218, 0, 1, 1'b1);
    add_entry(OP_FETCH, 16'h0328, 0, 2, 1'b1);
    add_entry(OP_FETCH, 16'h043c, 0, 1, 1'b1);
    // five tags in set 5
    add_entry(OP_FETCH, 16'h1050, 0, 1, 1'b0);
    add_entry(OP_FETCH, 16'h2054, 0, 1, 1'b0);
    add_entry(OP_FETCH, 16'h3058, 0, 1, 1'b0);
    add_entry(OP_FETCH, 16'h405c, 0, 1, 1'b0);
    add_entry(OP_FETCH, 16'h1050, 0, 1, 1'b1);
    add_entry(OP_FETCH, 16'h2050, 0, 1, 1'b1);
    add_entry(OP_FETCH, 16'h5050, 0, 1, 1'b0);
    add_entry(OP_FETCH, 16'h1054, 0, 1, 1'b1);
    add_entry(OP_FETCH, 16'h2058, 0, 1, 1'b1);
    add_entry(OP_FETCH, 16'h405c, 0, 1, 1'b1);
    add_entry(OP_FETCH, 16'h5054, 0, 1, 1'b1);
    add_entry(OP_FETCH, 16'h3050, 0, 1, 1'b0);
    add_entry(OP_FETCH, 16'h1050, 0, 1, 1'b0);
    // one-way invalidation in set 0
    add_entry(OP_FETCH, 16'h0900, 0, 1, 1'b0);
    add_entry(OP_INV_WAY, 16'h0000, 0, 1, 1'b0);
    add_entry(OP_FETCH, 16'h0904, 0, 1, 1'b1);
    add_entry(OP_FETCH, 16'h0100, 0, 1, 1'b0);
    add_entry(OP_FETCH, 16'h0108, 0, 1, 1'b1);
    // whole-set invalidation in set 1
    add_entry(OP_FETCH, 16'h0a14, 0, 1, 1'b0);
    add_entry(OP_INV_SET, 16'h0010, 0, 1, 1'b0);
    add_entry(OP_FETCH, 16'h0214, 0, 1, 1'b0);
    add_entry(OP_FETCH, 16'h0a10, 0, 1, 1'b0);
    add_entry(OP_FETCH, 16'h0218, 0, 1, 1'b1);
    // everything misses once after the flush
    add_entry(OP_FLUSH, 16'h0000, 0, 1, 1'b0);
    add_entry(OP_FETCH, 16'h0100, 0, 1, 1'b0);
    add_entry(OP_FETCH, 16'h0328, 0, 1, 1'b0);
    add_entry(OP_FETCH, 16'h5050, 0, 1, 1'b0);
    add_entry(OP_FETCH, 16'h043c, 0, 1, 1'b0);
    add_entry(OP_FETCH, 16'h0900, 0, 1, 1'b0);
    add_entry(OP_FETCH, 16'h0104, 0, 1, 1'b1);
    add_entry(OP_FETCH, 16'h0904, 0, 3, 1'b1);
  endtask

  task automatic wait_ready();
    @(negedge clk_i);
    while (!ready_o) begin
      @(negedge clk_i);
    end
  endtask

  // memory side of one miss starting in the middle of the compare cycle
  task automatic serve_miss(input logic [15:0] a, input int s, input int victim);
    int ack_dly;
    int rtrn_dly;
    draw_bits(2, ack_dly);
    repeat (ack_dly) begin
      @(posedge clk_i);
      #2;
      @(negedge clk_i);
      check_val(32'(mem_req_o), 32'd1, "mem_req_o held until ack");
    end
    @(posedge clk_i);
    #2;
    mem_ack_i = 1'b1;
    @(negedge clk_i);
    check_val(32'(miss_o), 32'd1, "miss_o in ack cycle");
    @(posedge clk_i);
    #2;
    mem_ack_i = 1'b0;
    draw_bits(2, rtrn_dly);
    repeat (rtrn_dly) begin
      @(posedge clk_i);
      #2;
    end
    rtrn_vld_i  = 1'b1;
    rtrn_type_i = icache_pkg::RTRN_FILL;
    rtrn_i.fill = line_of(a);
    @(negedge clk_i);
    check_val(32'(valid_o), 32'd1, "valid_o with fill return");
    check_val(data_o, word_of(a), "miss data");
    @(posedge clk_i);
    #2;
    rtrn_vld_i = 1'b0;
    rtrn_i     = '0;
    m_tag[s][victim]   = a[15:8];
    m_valid[s][victim] = 1'b1;
    update_ages(s, victim);
    exp_miss  = exp_miss + 1;
    exp_valid = exp_valid + 1;
  endtask

  task automatic fetch_words(input logic [15:0] addr, input int count, input logic exp_hit);
    logic [15:0] a;
    int          s;
    int          way;
    int          victim;
    req_i   = 1'b1;
    paddr_i = addr;
    wait_ready();
    for (int k = 0; k < count; k++) begin
      a = addr + 16'(4 * k);
      @(posedge clk_i);
      #2;
      if (k + 1 < count) begin
        paddr_i = addr + 16'(4 * (k + 1));
      end else begin
        req_i = 1'b0;
      end
      @(negedge clk_i);
      s   = int'(a[7:4]);
      way = find_way(s, a[15:8]);
      check_val(32'(way >= 0), 32'(exp_hit), "reference model hit");
      check_val(32'(valid_o), 32'(exp_hit), "valid_o one cycle after acceptance");
      if (exp_hit) begin
        check_val(data_o, word_of(a), "hit data");
        check_val(32'(mem_req_o), 32'd0, "mem_req_o on hit");
        update_ages(s, way);
        exp_valid = exp_valid + 1;
        if (k + 1 < count) begin
          check_val(32'(ready_o), 32'd1, "ready_o for back-to-back hit");
        end
      end else begin
        victim = pick_victim(s);
        check_val(32'(mem_req_o), 32'd1, "mem_req_o on miss");
        check_val(32'(mem_addr_o), 32'({a[15:4], 4'b0000}), "line address");
        check_val(32'(mem_way_o), 32'(victim), "replacement way");
        serve_miss(a, s, victim);
      end
    end
  endtask

  task automatic send_invalidation(input int s, input int w, input logic whole_set);
    icache_pkg::inv_req_t rec;
    rec          = '0;
    rec.idx      = 4'(s);
    rec.way      = 2'(w);
    rec.one_way  = !whole_set;
    rec.all_ways = whole_set;
    rtrn_vld_i   = 1'b1;
    rtrn_type_i  = icache_pkg::RTRN_INV;
    rtrn_i.inv   = rec;
    @(negedge clk_i);
    check_val(32'(ready_o), 32'd0, "ready_o during invalidation");
    @(posedge clk_i);
    #2;
    rtrn_vld_i  = 1'b0;
    rtrn_type_i = icache_pkg::RTRN_FILL;
    rtrn_i      = '0;
    for (int i = 0; i < icache_pkg::NUM_WAYS; i++) begin
      if (whole_set || i == w) begin
        m_valid[s][i] = 1'b0;
      end
    end
  endtask

  task automatic request_flush();
    flush_i = 1'b1;
    @(posedge clk_i);
    #2;
    flush_i = 1'b0;
    clear_model();
  endtask

  ////////////////////
  // main sequence
  ////////////////////

  initial begin
    logic [1:0]  op;
    logic [15:0] addr;
    clk_i       = 1'b0;
    rst_ni      = 1'b0;
    flush_i     = 1'b0;
    req_i       = 1'b0;
    paddr_i     = '0;
    mem_ack_i   = 1'b0;
    rtrn_vld_i  = 1'b0;
    rtrn_type_i = icache_pkg::RTRN_FILL;
    rtrn_i      = '0;
    lfsr_q      = 32'd79931;
    flush_ops   = 0;
    cycle_cnt   = 0;
    miss_cnt    = 0;
    valid_cnt   = 0;
    exp_miss    = 0;
    exp_valid   = 0;
    build_table();
    // reset plus the flush after reset and each table flush
    cycle_limit = stim_q.size() * 20 + 8 + icache_pkg::NUM_SETS * (1 + flush_ops);
    clear_model();
    repeat (8) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    for (int i = 0; i < stim_q.size(); i++) begin
      @(posedge clk_i);
      #2;
      check_val(32'(miss_cnt), 32'(exp_miss), "miss_o pulse count");
      check_val(32'(valid_cnt), 32'(exp_valid), "valid_o pulse count");
      op   = stim_q[i][23:22];
      addr = stim_q[i][15:0];
      case (op)
        OP_FETCH:   fetch_words(addr, int'(stim_q[i][20:18]), stim_q[i][21]);
        OP_INV_WAY: send_invalidation(int'(addr[7:4]), int'(stim_q[i][17:16]), 1'b0);
        OP_INV_SET: send_invalidation(int'(addr[7:4]), 0, 1'b1);
        default:    request_flush();
      endcase
    end
    repeat (3) @(posedge clk_i);
    #2;
    check_val(32'(miss_cnt), 32'(exp_miss), "final miss_o pulse count");
    check_val(32'(valid_cnt), 32'(exp_valid), "final valid_o pulse count");
    $display("RESULT: PASS");
    $finish;
  end

endmodule

//--- project.f
hdl/icache_pkg.sv
hdl/icache_ctrl.sv
hdl/icache_arrays.sv
hdl/icache_hit_select.sv
hdl/icache_lru.sv
hdl/icache_top.sv
test/tb_icache.sv

//--- run.sh
#!/bin/sh
# build the icache testbench with Verilator, run it and scan the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f project.f --top-module tb_icache -o sim_icache

# the log decides pass or fail
./obj_dir/sim_icache | tee sim.log

if grep -q "RESULT: FAIL" sim.log; then
  echo "simulation reported a failure"
  exit 1
fi
grep -q "RESULT: PASS" sim.log
